//--- Bender.yml
package:
  name: accel_tile

sources:
  - verilog/accel_pkg.sv
  - verilog/simple_fifo.sv
  - verilog/pkt_mem.sv
  - verilog/accel_rd_dma.sv
  - verilog/pattern_matcher.sv
  - verilog/ip_match.sv
  - verilog/accel_wrap.sv
  - verilog/accel_top.sv
  - target: test
    files:
      - test/tb_clk_gen.sv
      - test/tb_accel.sv

//--- tb.f
verilog/accel_pkg.sv
verilog/simple_fifo.sv
verilog/pkt_mem.sv
verilog/accel_rd_dma.sv
verilog/pattern_matcher.sv
verilog/ip_match.sv
verilog/accel_wrap.sv
verilog/accel_top.sv
test/tb_clk_gen.sv
test/tb_accel.sv

//--- test/tb_accel.sv
`timescale 1ns/1ps

module tb_accel;

  import accel_pkg::*;

  localparam int MEM_LINES  = 256;
  localparam int RULE_COUNT = 8;
  localparam int IP_ENTRIES = 8;
  localparam int SLOT_COUNT = 4;
  localparam int MW         = $clog2(MEM_LINES);
  localparam int MAX_LEN    = 40;
  // About 40 packets in all, none of them near 500 cycles end to end
  localparam int PKT_COUNT   = 40;
  localparam int PKT_CYCLES  = 500;
  localparam int CYCLE_LIMIT = PKT_COUNT * PKT_CYCLES;

  logic                   clk;
  logic                   rst;
  logic                   io_en;
  logic                   io_wen;
  logic [io_data_w/8-1:0] io_strb;
  logic [io_addr_w-1:0]   io_addr;
  logic [io_data_w-1:0]   io_wr_data;
  logic [io_data_w-1:0]   io_rd_data;
  logic                   io_rd_valid;
  logic                   tbl_wr_en;
  logic [io_addr_w-1:0]   tbl_wr_addr;
  logic [31:0]            tbl_wr_data;
  logic                   mem_wr_en;
  logic [MW-1:0]          mem_wr_addr;
  logic [31:0]            mem_wr_data;

  logic [15:0]          lfsr_state;
  logic [31:0]          rule_tbl [RULE_COUNT];
  logic [31:0]          ip_tbl [IP_ENTRIES];
  logic [7:0]           pkt [3][MAX_LEN];
  int                   pkt_len [3];
  int                   rd_wait;
  int                   cycles = 0;
  logic [io_data_w-1:0] rd;
  logic [io_data_w-1:0] val;

  tb_clk_gen clk_gen (
    .clk(clk),
    .rst(rst)
  );

  accel_top #(
    .MEM_LINES (MEM_LINES),
    .RULE_COUNT(RULE_COUNT),
    .IP_ENTRIES(IP_ENTRIES),
    .SLOT_COUNT(SLOT_COUNT)
  ) UUT (
    .clk        (clk),
    .rst        (rst),
    .io_en      (io_en),
    .io_wen     (io_wen),
    .io_strb    (io_strb),
    .io_addr    (io_addr),
    .io_wr_data (io_wr_data),
    .io_rd_data (io_rd_data),
    .io_rd_valid(io_rd_valid),
    .tbl_wr_en  (tbl_wr_en),
    .tbl_wr_addr(tbl_wr_addr),
    .tbl_wr_data(tbl_wr_data),
    .mem_wr_en  (mem_wr_en),
    .mem_wr_addr(mem_wr_addr),
    .mem_wr_data(mem_wr_data)
  );

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] rand_bits(input int nbits);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] swap_bytes(input logic [31:0] v);
    return {v[7:0], v[15:8], v[23:16], v[31:24]};
  endfunction

  // First pair in byte order wins, then the lowest rule index
  function automatic logic [rule_id_w:0] ref_match(input int idx);
    logic [rule_id_w:0] res;
    res = '0;
    for (int i = 1; i < pkt_len[idx]; i++) begin
      for (int r = 0; r < RULE_COUNT; r++) begin
        if (!res[rule_id_w] && pkt[idx][i-1] == rule_tbl[r][7:0] &&
            pkt[idx][i] == rule_tbl[r][15:8]) begin
          res = {1'b1, rule_tbl[r][31:16]};
        end
      end
    end
    return res;
  endfunction

  function automatic logic ref_ip(input logic [31:0] src);
    logic hit;
    hit = 1'b0;
    for (int k = 0; k < IP_ENTRIES; k++) begin
      if (ip_tbl[k] == swap_bytes(src)) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic check_word(input string name, input logic [io_data_w-1:0] exp,
                            input logic [io_data_w-1:0] act);
    if (act !== exp) begin
      stop_with_failure($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_rule(input string name, input logic [rule_id_w-1:0] exp,
                            input logic [rule_id_w-1:0] act);
    if (act !== exp) begin
      stop_with_failure($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
    end
  endtask

  // Bus tasks start and end right after a falling edge
  task automatic io_write(input logic [io_addr_w-1:0] addr, input logic [io_data_w-1:0] data,
                          input logic [io_data_w/8-1:0] strb);
    io_en      = 1'b1;
    io_wen     = 1'b1;
    io_addr    = addr;
    io_wr_data = data;
    io_strb    = strb;
    @(negedge clk);
    io_en  = 1'b0;
    io_wen = 1'b0;
  endtask

  task automatic io_read(input logic [io_addr_w-1:0] addr, output logic [io_data_w-1:0] data);
    io_en   = 1'b1;
    io_wen  = 1'b0;
    io_addr = addr;
    @(negedge clk);
    io_en   = 1'b0;
    io_addr = '0;
    rd_wait = 0;
    while (io_rd_valid !== 1'b1) begin
      @(negedge clk);
      rd_wait++;
    end
    data = io_rd_data;
  endtask

  task automatic tbl_write(input logic [io_addr_w-1:0] addr, input logic [31:0] data);
    tbl_wr_en   = 1'b1;
    tbl_wr_addr = addr;
    tbl_wr_data = data;
    @(negedge clk);
    tbl_wr_en = 1'b0;
  endtask

  task automatic mem_write(input int line, input logic [31:0] data);
    mem_wr_en   = 1'b1;
    mem_wr_addr = MW'(line);
    mem_wr_data = data;
    @(negedge clk);
    mem_wr_en = 1'b0;
  endtask

  task automatic load_tables();
    for (int r = 0; r < RULE_COUNT; r++) begin
      rule_tbl[r] = rand_bits(32);
      tbl_write({tbl_rules, 7'(r)}, rule_tbl[r]);
    end
    for (int k = 0; k < IP_ENTRIES; k++) begin
      ip_tbl[k] = rand_bits(32);
      tbl_write({tbl_ip, 7'(k)}, ip_tbl[k]);
    end
  endtask

  task automatic make_packet(input int idx, input int len, input bit plant);
    int r;
    int pos;
    pkt_len[idx] = len;
    for (int i = 0; i < len; i++) begin
      pkt[idx][i] = rand_bits(8);
    end
    if (plant && len > 1) begin
      r   = rand_bits(3) % RULE_COUNT;
      pos = 1 + rand_bits(6) % (len - 1);
      // Sometimes put the pair across a beat boundary
      if (rand_bits(1) && len > 4) begin
        pos = 4 * (1 + rand_bits(4) % ((len - 1) / 4));
      end
      pkt[idx][pos-1] = rule_tbl[r][7:0];
      pkt[idx][pos]   = rule_tbl[r][15:8];
    end
  endtask

  // Lanes past the packet end get random filler
  task automatic load_packet(input int idx, input int base);
    logic [31:0] word;
    for (int w = 0; w < (pkt_len[idx] + 3) / 4; w++) begin
      word = rand_bits(32);
      for (int b = 0; b < 4; b++) begin
        if (4 * w + b < pkt_len[idx]) begin
          word[8*b +: 8] = pkt[idx][4*w+b];
        end
      end
      mem_write(base + w, word);
    end
  endtask

  task automatic start_packet(input int idx, input int base, input logic [7:0] slot);
    io_write(reg_len, io_data_w'(pkt_len[idx]), 4'hf);
    io_write(reg_addr, io_data_w'(base), 4'hf);
    io_write(reg_slot, io_data_w'(slot), 4'hf);
    io_write(reg_ctrl, io_data_w'(1) << ctrl_start, 4'h1);
  endtask

  task automatic verify_result(input string name, input int idx);
    logic [io_data_w-1:0] ctrl;
    logic [rule_id_w:0]   exp;
    exp  = ref_match(idx);
    ctrl = '0;
    while (ctrl[0] !== 1'b1) begin
      io_read(reg_ctrl, ctrl);
    end
    check_word(name, io_data_w'({exp[rule_id_w], 1'b1}), ctrl);
    io_read(reg_rule, ctrl);
    check_rule(name, exp[rule_id_w-1:0], ctrl[rule_id_w-1:0]);
  endtask

  // Two idle cycles let the cleared result reach reg_ctrl
  task automatic release_result();
    io_write(reg_ctrl, io_data_w'(1) << ctrl_release, 4'h1);
    repeat (2) @(negedge clk);
  endtask

  task automatic register_readback();
    val = rand_bits(32);
    io_write(reg_len, val, 4'hf);
    io_read(reg_len, rd);
    check_word("len readback", val, rd);
    val = rand_bits(32);
    io_write(reg_addr, val, 4'hf);
    io_read(reg_addr, rd);
    check_word("addr readback", val, rd);
    // Start without strobe bit 0 must not launch anything
    io_write(reg_len, 32'd4, 4'hf);
    io_write(reg_addr, 32'd0, 4'hf);
    io_write(reg_ctrl, io_data_w'(1) << ctrl_start, 4'b1110);
    repeat (20) @(negedge clk);
    io_read(reg_ctrl, rd);
    check_word("ctrl without strobe", 32'd0, rd);
    io_read(reg_dma_stat, rd);
    check_word("dma idle", 32'h0000_0001, rd);
  endtask

  task automatic random_matching();
    for (int n = 0; n < 30; n++) begin
      make_packet(0, 1 + rand_bits(6) % MAX_LEN, n % 4 != 3);
      load_packet(0, 64);
      start_packet(0, 64, 8'(n));
      verify_result("random match", 0);
      release_result();
      io_read(reg_ctrl, rd);
      check_word("release clears", 32'd0, rd);
    end
  endtask

  task automatic queued_packets();
    for (int k = 0; k < 3; k++) begin
      make_packet(k, 1 + rand_bits(6) % MAX_LEN, 1'b1);
      load_packet(k, 16 * k);
    end
    for (int k = 0; k < 3; k++) begin
      start_packet(k, 16 * k, 8'h30 + 8'(k));
    end
    for (int k = 0; k < 3; k++) begin
      verify_result("queued match", k);
      io_read(reg_slot, rd);
      check_word("slot order", 32'h100 | (32'h30 + k), rd);
      release_result();
    end
  endtask

  task automatic ip_blocklist();
    logic [31:0] src;
    for (int t = 0; t < 6; t++) begin
      src = (t % 2 == 0) ? swap_bytes(ip_tbl[rand_bits(3) % IP_ENTRIES]) : rand_bits(32);
      io_write(reg_src_ip, src, 4'hf);
      io_read(reg_ip_stat, rd);
      if (rd_wait < IP_ENTRIES) begin
        stop_with_failure("IP status read returned before the blocklist scan could finish");
      end
      check_word("ip status", io_data_w'(ref_ip(src)), rd);
      io_read(reg_src_ip, rd);
      check_word("src ip readback", src, rd);
    end
  endtask

  task automatic dma_status();
    make_packet(0, 12, 1'b1);
    load_packet(0, 48);
    start_packet(0, 48, 8'h50);
    verify_result("dma first packet", 0);
    // First completed packet, so done is up and done_err still low
    io_read(reg_dma_stat, rd);
    check_word("dma done", 32'h0000_0101, rd);
    // Long packet stalls behind the unreleased result, then gets stopped
    make_packet(1, MAX_LEN, 1'b1);
    load_packet(1, 64);
    start_packet(1, 64, 8'h51);
    repeat (8) @(negedge clk);
    io_write(reg_ctrl, io_data_w'(1) << ctrl_stop, 4'h1);
    repeat (2) @(negedge clk);
    io_read(reg_dma_stat, rd);
    check_word("dma stop", 32'h0001_0100, rd);
    pkt_len[1] = 0;
    release_result();
    verify_result("stopped packet", 1);
    io_read(reg_slot, rd);
    check_word("stopped slot", 32'h151, rd);
    release_result();
    make_packet(2, 1 + rand_bits(6) % MAX_LEN, 1'b1);
    load_packet(2, 80);
    start_packet(2, 80, 8'h52);
    verify_result("after stop", 2);
    release_result();
    io_read(reg_ctrl, rd);
    check_word("final release", 32'd0, rd);
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == CYCLE_LIMIT) begin
      stop_with_failure($sformatf("Timeout after %0d cycles", CYCLE_LIMIT));
    end
  end

  initial begin
    lfsr_state  = 16'd22;
    io_en       = 1'b0;
    io_wen      = 1'b0;
    io_strb     = '0;
    io_addr     = '0;
    io_wr_data  = '0;
    tbl_wr_en   = 1'b0;
    tbl_wr_addr = '0;
    tbl_wr_data = '0;
    mem_wr_en   = 1'b0;
    mem_wr_addr = '0;
    mem_wr_data = '0;
    wait (rst === 1'b0);
    repeat (2) @(negedge clk);
    load_tables();
    register_readback();
    dma_status();
    random_matching();
    queued_packets();
    ip_blocklist();
    $display("Test passed");
    $finish;
  end

endmodule

//--- test/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 5
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Reset leaves on a falling edge, away from the DUT's sampling edge
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

//--- verilog/accel_pkg.sv
package accel_pkg;

  // Host register port
  localparam int io_data_w = 32;
  localparam int io_addr_w = 8;

  localparam int len_w     = 14;
  localparam int rule_id_w = 16;

  // Register byte offsets
  localparam logic [io_addr_w-1:0] reg_ctrl     = 8'h00;
  localparam logic [io_addr_w-1:0] reg_len      = 8'h04;
  localparam logic [io_addr_w-1:0] reg_addr     = 8'h08;
  localparam logic [io_addr_w-1:0] reg_slot     = 8'h18;
  localparam logic [io_addr_w-1:0] reg_rule     = 8'h1c;
  localparam logic [io_addr_w-1:0] reg_src_ip   = 8'h40;
  localparam logic [io_addr_w-1:0] reg_ip_stat  = 8'h60;
  localparam logic [io_addr_w-1:0] reg_dma_stat = 8'h70;

  // Bit positions in reg_ctrl
  typedef enum logic [1:0] {
    ctrl_start   = 2'd0,
    ctrl_release = 2'd1,
    ctrl_stop    = 2'd2
  } ctrl_bit_e;

  typedef enum logic [1:0] {dma_st_idle, dma_st_read, dma_st_drain} dma_state_e;

  typedef enum logic [1:0] {ip_st_idle, ip_st_scan, ip_st_done} ip_state_e;

  // Top bit of the table write address
  typedef enum logic {tbl_rules, tbl_ip} tbl_sel_e;

endpackage

//--- verilog/accel_rd_dma.sv
`timescale 1ns/1ps

module accel_rd_dma #(
  parameter int MEM_LINES = 256
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [$clog2(MEM_LINES)-1:0] desc_addr,
  input  logic [accel_pkg::len_w-1:0]  desc_len,
  input  logic                         desc_valid,
  output logic                         desc_ready,
  input  logic                         stop,
  output logic                         mem_rd_en,
  output logic [$clog2(MEM_LINES)-1:0] mem_rd_addr,
  input  logic [31:0]                  mem_rd_data,
  output logic [31:0]                  m_tdata,
  output logic [2:0]                   m_tbytes,
  output logic                         m_tlast,
  output logic                         m_tvalid,
  input  logic                         m_tready
);

  import accel_pkg::*;

  dma_state_e       state;
  logic [len_w-1:0] bytes_left;
  logic [2:0]       beat_bytes;
  logic             beat_last;
  logic             inflight;
  logic [3:0]       inflight_meta;
  // Skid entries hold {last, bytes, data}, head at index 0
  logic [35:0]      skid [2];
  logic [1:0]       sk_cnt;
  logic [1:0]       occ;
  logic             wr_idx;
  logic             pop;
  logic             issue;
  logic             abort;

  assign m_tvalid = sk_cnt != 2'd0;
  assign {m_tlast, m_tbytes, m_tdata} = skid[0];
  assign pop = m_tvalid && m_tready;

  // Words in the skid plus the one still coming back from memory
  assign occ    = sk_cnt + {1'b0, inflight};
  assign wr_idx = sk_cnt[0] && !pop;
  assign abort  = stop && (state != dma_st_idle) && !(pop && m_tlast);
  assign issue  = (state == dma_st_read) && !abort && (occ < 2'd2 || pop);

  assign mem_rd_en  = issue;
  assign beat_last  = bytes_left <= len_w'(4);
  assign beat_bytes = beat_last ? bytes_left[2:0] : 3'd4;

  always_ff @(posedge clk) begin
    if (desc_ready && desc_valid) begin
      mem_rd_addr <= desc_addr;
      bytes_left  <= desc_len;
    end else if (issue) begin
      mem_rd_addr <= mem_rd_addr + 1'b1;
      bytes_left  <= bytes_left - len_w'(beat_bytes);
    end
    if (issue) begin
      inflight_meta <= {beat_last, beat_bytes};
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      skid[0] <= skid[1];
    end
    if (inflight) begin
      skid[wr_idx] <= {inflight_meta, mem_rd_data};
    end
    // Stop replaces whatever is queued with an empty last beat
    if (abort) begin
      skid[0] <= {1'b1, 3'd0, 32'd0};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= dma_st_idle;
      desc_ready <= 1'b0;
      inflight   <= 1'b0;
      sk_cnt     <= 2'd0;
    end else begin
      inflight <= issue;
      sk_cnt   <= sk_cnt + {1'b0, inflight} - {1'b0, pop};
      case (state)
        dma_st_idle: begin
          desc_ready <= 1'b1;
          if (desc_ready && desc_valid) begin
            desc_ready <= 1'b0;
            state      <= dma_st_read;
          end
        end
        dma_st_read: begin
          if (issue && beat_last) begin
            state <= dma_st_drain;
          end
        end
        default: begin
          if (pop && m_tlast) begin
            state      <= dma_st_idle;
            desc_ready <= 1'b1;
          end
        end
      endcase
      if (abort) begin
        state    <= dma_st_drain;
        inflight <= 1'b0;
        sk_cnt   <= 2'd1;
      end
    end
  end

endmodule

//--- verilog/accel_top.sv
`timescale 1ns/1ps

module accel_top #(
  parameter int MEM_LINES  = 256,
  parameter int RULE_COUNT = 8,
  parameter int IP_ENTRIES = 8,
  parameter int SLOT_COUNT = 4
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              io_en,
  input  logic                              io_wen,
  input  logic [accel_pkg::io_data_w/8-1:0] io_strb,
  input  logic [accel_pkg::io_addr_w-1:0]   io_addr,
  input  logic [accel_pkg::io_data_w-1:0]   io_wr_data,
  output logic [accel_pkg::io_data_w-1:0]   io_rd_data,
  output logic                              io_rd_valid,
  input  logic                              tbl_wr_en,
  input  logic [accel_pkg::io_addr_w-1:0]   tbl_wr_addr,
  input  logic [31:0]                       tbl_wr_data,
  input  logic                              mem_wr_en,
  input  logic [$clog2(MEM_LINES)-1:0]      mem_wr_addr,
  input  logic [31:0]                       mem_wr_data
);

  logic                         mem_rd_en;
  logic [$clog2(MEM_LINES)-1:0] mem_rd_addr;
  logic [31:0]                  mem_rd_data;

  // Host fills packets, the tile only reads them
  pkt_mem #(
    .MEM_LINES(MEM_LINES)
  ) packet_mem (
    .clk    (clk),
    .wr_en  (mem_wr_en),
    .wr_addr(mem_wr_addr),
    .wr_data(mem_wr_data),
    .rd_en  (mem_rd_en),
    .rd_addr(mem_rd_addr),
    .rd_data(mem_rd_data)
  );

  accel_wrap #(
    .MEM_LINES (MEM_LINES),
    .RULE_COUNT(RULE_COUNT),
    .IP_ENTRIES(IP_ENTRIES),
    .SLOT_COUNT(SLOT_COUNT)
  ) wrap (
    .clk        (clk),
    .rst        (rst),
    .io_en      (io_en),
    .io_wen     (io_wen),
    .io_strb    (io_strb),
    .io_addr    (io_addr),
    .io_wr_data (io_wr_data),
    .io_rd_data (io_rd_data),
    .io_rd_valid(io_rd_valid),
    .tbl_wr_en  (tbl_wr_en),
    .tbl_wr_addr(tbl_wr_addr),
    .tbl_wr_data(tbl_wr_data),
    .mem_rd_en  (mem_rd_en),
    .mem_rd_addr(mem_rd_addr),
    .mem_rd_data(mem_rd_data)
  );

endmodule

//--- verilog/accel_wrap.sv
`timescale 1ns/1ps

module accel_wrap #(
  parameter int MEM_LINES  = 256,
  parameter int RULE_COUNT = 8,
  parameter int IP_ENTRIES = 8,
  parameter int SLOT_COUNT = 4
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              io_en,
  input  logic                              io_wen,
  input  logic [accel_pkg::io_data_w/8-1:0] io_strb,
  input  logic [accel_pkg::io_addr_w-1:0]   io_addr,
  input  logic [accel_pkg::io_data_w-1:0]   io_wr_data,
  output logic [accel_pkg::io_data_w-1:0]   io_rd_data,
  output logic                              io_rd_valid,
  input  logic                              tbl_wr_en,
  input  logic [accel_pkg::io_addr_w-1:0]   tbl_wr_addr,
  input  logic [31:0]                       tbl_wr_data,
  output logic                              mem_rd_en,
  output logic [$clog2(MEM_LINES)-1:0]      mem_rd_addr,
  input  logic [31:0]                       mem_rd_data
);

  import accel_pkg::*;

  localparam int AW = $clog2(MEM_LINES);

  logic                 wr_en;
  logic                 rd_en;
  logic                 ctrl_wr;
  logic [io_data_w-1:0] rd_mux;
  logic                 rd_stall;

  logic [io_data_w-1:0] cmd_len;
  logic [io_data_w-1:0] cmd_addr;
  logic [7:0]           cmd_slot;
  logic [31:0]          src_ip;
  logic                 src_ip_valid;
  logic                 cmd_start;
  logic                 cmd_release;
  logic                 cmd_stop;

  logic                 desc_valid;
  logic                 desc_ready;
  logic [AW-1:0]        desc_addr;
  logic [len_w-1:0]     desc_len;
  logic                 slot_valid;
  logic [7:0]           slot_head;

  logic [31:0]          s_tdata;
  logic [2:0]           s_tbytes;
  logic                 s_tlast;
  logic                 s_tvalid;
  logic                 s_tready;

  logic                 match_valid;
  logic                 match_hit;
  logic [rule_id_w-1:0] match_rule_id;
  logic                 ip_hit;
  logic                 ip_done;
  logic                 dma_done;
  logic                 dma_done_err;
  tbl_sel_e             tbl_sel;

  assign wr_en   = io_en && io_wen;
  assign rd_en   = io_en && !io_wen;
  assign ctrl_wr = wr_en && (io_addr == reg_ctrl) && io_strb[0];
  assign tbl_sel = tbl_sel_e'(tbl_wr_addr[io_addr_w-1]);

  always_comb begin
    case (io_addr)
      reg_ctrl:     rd_mux = io_data_w'({match_hit, match_valid});
      reg_len:      rd_mux = cmd_len;
      reg_addr:     rd_mux = cmd_addr;
      reg_slot:     rd_mux = io_data_w'({slot_valid, slot_head});
      reg_rule:     rd_mux = io_data_w'(match_rule_id);
      reg_src_ip:   rd_mux = src_ip;
      reg_ip_stat:  rd_mux = io_data_w'(ip_hit);
      reg_dma_stat: rd_mux = {15'd0, dma_done_err, 7'd0, dma_done, 7'd0, desc_ready};
      default:      rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      case (io_addr)
        reg_len:    cmd_len  <= io_wr_data;
        reg_addr:   cmd_addr <= io_wr_data;
        reg_slot:   cmd_slot <= io_wr_data[7:0];
        reg_src_ip: src_ip   <= io_wr_data;
        default:    ;
      endcase
    end
    if (rd_en) begin
      io_rd_data <= rd_mux;
    end else if (rd_stall) begin
      io_rd_data <= io_data_w'(ip_hit);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cmd_start    <= 1'b0;
      cmd_release  <= 1'b0;
      cmd_stop     <= 1'b0;
      src_ip_valid <= 1'b0;
      io_rd_valid  <= 1'b0;
      rd_stall     <= 1'b0;
      dma_done     <= 1'b0;
      dma_done_err <= 1'b0;
    end else begin
      cmd_start    <= ctrl_wr && io_wr_data[ctrl_start];
      cmd_release  <= ctrl_wr && io_wr_data[ctrl_release];
      cmd_stop     <= ctrl_wr && io_wr_data[ctrl_stop];
      src_ip_valid <= wr_en && (io_addr == reg_src_ip);
      io_rd_valid  <= 1'b0;
      // IP status waits for a check that is running or about to start
      if (rd_en && io_addr == reg_ip_stat) begin
        io_rd_valid <= ip_done && !src_ip_valid;
        rd_stall    <= !ip_done || src_ip_valid;
      end else if (rd_en) begin
        io_rd_valid <= 1'b1;
      end else if (rd_stall) begin
        io_rd_valid <= ip_done;
        rd_stall    <= !ip_done;
      end
      dma_done     <= dma_done || (s_tvalid && s_tready && s_tlast) || cmd_stop;
      dma_done_err <= dma_done_err || (dma_done && !desc_ready);
    end
  end

  simple_fifo #(
    .DEPTH(SLOT_COUNT),
    .WIDTH(AW + len_w)
  ) desc_fifo (
    .clk       (clk),
    .rst       (rst),
    .din_valid (cmd_start),
    .din       ({cmd_addr[AW-1:0], cmd_len[len_w-1:0]}),
    .din_ready (),
    .dout_valid(desc_valid),
    .dout      ({desc_addr, desc_len}),
    .dout_ready(desc_ready)
  );

  // Slot leaves when the host releases the result of its packet
  simple_fifo #(
    .DEPTH(SLOT_COUNT),
    .WIDTH(8)
  ) slot_fifo (
    .clk       (clk),
    .rst       (rst),
    .din_valid (cmd_start),
    .din       (cmd_slot),
    .din_ready (),
    .dout_valid(slot_valid),
    .dout      (slot_head),
    .dout_ready(cmd_release && match_valid)
  );

  accel_rd_dma #(
    .MEM_LINES(MEM_LINES)
  ) rd_dma (
    .clk        (clk),
    .rst        (rst),
    .desc_addr  (desc_addr),
    .desc_len   (desc_len),
    .desc_valid (desc_valid),
    .desc_ready (desc_ready),
    .stop       (cmd_stop),
    .mem_rd_en  (mem_rd_en),
    .mem_rd_addr(mem_rd_addr),
    .mem_rd_data(mem_rd_data),
    .m_tdata    (s_tdata),
    .m_tbytes   (s_tbytes),
    .m_tlast    (s_tlast),
    .m_tvalid   (s_tvalid),
    .m_tready   (s_tready)
  );

  pattern_matcher #(
    .RULE_COUNT(RULE_COUNT)
  ) matcher (
    .clk          (clk),
    .rst          (rst),
    .tbl_wr_en    (tbl_wr_en && tbl_sel == tbl_rules),
    .tbl_wr_index (tbl_wr_addr[$clog2(RULE_COUNT)-1:0]),
    .tbl_wr_data  (tbl_wr_data),
    .s_tdata      (s_tdata),
    .s_tbytes     (s_tbytes),
    .s_tlast      (s_tlast),
    .s_tvalid     (s_tvalid),
    .s_tready     (s_tready),
    .match_release(cmd_release),
    .match_valid  (match_valid),
    .match_hit    (match_hit),
    .match_rule_id(match_rule_id)
  );

  // Network byte order on the host side
  ip_match #(
    .IP_ENTRIES(IP_ENTRIES)
  ) ip_check (
    .clk         (clk),
    .rst         (rst),
    .tbl_wr_en   (tbl_wr_en && tbl_sel == tbl_ip),
    .tbl_wr_index(tbl_wr_addr[$clog2(IP_ENTRIES)-1:0]),
    .tbl_wr_data (tbl_wr_data),
    .addr        ({src_ip[7:0], src_ip[15:8], src_ip[23:16], src_ip[31:24]}),
    .valid       (src_ip_valid),
    .match       (ip_hit),
    .done        (ip_done)
  );

endmodule

//--- verilog/ip_match.sv
`timescale 1ns/1ps

module ip_match #(
  parameter int IP_ENTRIES = 8
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          tbl_wr_en,
  input  logic [$clog2(IP_ENTRIES)-1:0] tbl_wr_index,
  input  logic [31:0]                   tbl_wr_data,
  input  logic [31:0]                   addr,
  input  logic                          valid,
  output logic                          match,
  output logic                          done
);

  import accel_pkg::*;

  localparam int IW = $clog2(IP_ENTRIES);

  logic [31:0] entries [IP_ENTRIES];
  logic [31:0] addr_q;
  logic [IW-1:0] idx;
  ip_state_e   state;

  always_ff @(posedge clk) begin
    if (tbl_wr_en) begin
      entries[tbl_wr_index] <= tbl_wr_data;
    end
    if (valid) begin
      addr_q <= addr;
    end
  end

  // One blocklist entry per cycle, done one cycle after the last compare
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ip_st_idle;
      idx   <= '0;
      match <= 1'b0;
      done  <= 1'b0;
    end else if (valid) begin
      state <= ip_st_scan;
      idx   <= '0;
      match <= 1'b0;
      done  <= 1'b0;
    end else begin
      case (state)
        ip_st_scan: begin
          if (entries[idx] == addr_q) begin
            match <= 1'b1;
          end
          idx <= idx + 1'b1;
          if (idx == IW'(IP_ENTRIES - 1)) begin
            state <= ip_st_done;
          end
        end
        ip_st_done: begin
          done  <= 1'b1;
          state <= ip_st_idle;
        end
        default: begin
          state <= ip_st_idle;
        end
      endcase
    end
  end

endmodule

//--- verilog/pattern_matcher.sv
`timescale 1ns/1ps

module pattern_matcher #(
  parameter int RULE_COUNT = 8
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          tbl_wr_en,
  input  logic [$clog2(RULE_COUNT)-1:0] tbl_wr_index,
  input  logic [31:0]                   tbl_wr_data,
  input  logic [31:0]                   s_tdata,
  input  logic [2:0]                    s_tbytes,
  input  logic                          s_tlast,
  input  logic                          s_tvalid,
  output logic                          s_tready,
  input  logic                          match_release,
  output logic                          match_valid,
  output logic                          match_hit,
  output logic [accel_pkg::rule_id_w-1:0] match_rule_id
);

  import accel_pkg::*;

  // Rule entry is {rule_id, second_byte, first_byte}
  logic [31:0]          rules [RULE_COUNT];
  logic [7:0]           prev_byte;
  logic                 prev_valid;
  logic [39:0]          win;
  logic                 accept;
  logic                 found_q;
  logic [rule_id_w-1:0] id_q;
  logic                 beat_found;
  logic [rule_id_w-1:0] beat_id;

  assign s_tready = !match_valid;
  assign accept   = s_tvalid && s_tready;
  // Pair p is bytes p-1 and p of the beat, byte -1 being the carried one
  assign win      = {s_tdata, prev_byte};

  // Earliest pair position wins, then the lowest rule index
  always_comb begin
    beat_found = 1'b0;
    beat_id    = '0;
    for (int p = 0; p < 4; p++) begin
      for (int r = 0; r < RULE_COUNT; r++) begin
        if (!beat_found && (p < s_tbytes) && (p != 0 || prev_valid) &&
            win[8*p +: 16] == rules[r][15:0]) begin
          beat_found = 1'b1;
          beat_id    = rules[r][31:16];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (tbl_wr_en) begin
      rules[tbl_wr_index] <= tbl_wr_data;
    end
    if (accept) begin
      prev_byte <= win[8*s_tbytes +: 8];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      prev_valid    <= 1'b0;
      found_q       <= 1'b0;
      id_q          <= '0;
      match_valid   <= 1'b0;
      match_hit     <= 1'b0;
      match_rule_id <= '0;
    end else begin
      if (match_valid && match_release) begin
        match_valid   <= 1'b0;
        match_hit     <= 1'b0;
        match_rule_id <= '0;
      end
      if (accept && s_tlast) begin
        match_valid   <= 1'b1;
        match_hit     <= found_q || beat_found;
        match_rule_id <= found_q ? id_q : beat_id;
        found_q       <= 1'b0;
        id_q          <= '0;
        prev_valid    <= 1'b0;
      end else if (accept) begin
        if (!found_q && beat_found) begin
          found_q <= 1'b1;
          id_q    <= beat_id;
        end
        if (s_tbytes != 3'd0) begin
          prev_valid <= 1'b1;
        end
      end
    end
  end

endmodule

//--- verilog/pkt_mem.sv
`timescale 1ns/1ps

module pkt_mem #(
  parameter int MEM_LINES = 256
) (
  input  logic                         clk,
  input  logic                         wr_en,
  input  logic [$clog2(MEM_LINES)-1:0] wr_addr,
  input  logic [31:0]                  wr_data,
  input  logic                         rd_en,
  input  logic [$clog2(MEM_LINES)-1:0] rd_addr,
  output logic [31:0]                  rd_data
);

  logic [31:0] mem [MEM_LINES];

  // One word per line, read data one cycle after rd_en
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

//--- verilog/simple_fifo.sv
`timescale 1ns/1ps

module simple_fifo #(
  parameter int DEPTH = 4,
  parameter int WIDTH = 8
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             din_valid,
  input  logic [WIDTH-1:0] din,
  output logic             din_ready,
  output logic             dout_valid,
  output logic [WIDTH-1:0] dout,
  input  logic             dout_ready
);

  localparam int AW = $clog2(DEPTH);
  localparam int CW = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic [CW-1:0]    count;
  logic             push;
  logic             pop;
  logic             load;

  assign din_ready = count < CW'(DEPTH);
  assign push      = din_valid && din_ready;
  assign pop       = dout_valid && dout_ready;
  // Refill the output register whenever it is empty or being taken
  assign load      = (count != '0) && (!dout_valid || dout_ready);

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= din;
    end
    if (load) begin
      dout <= mem[rd_ptr];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      dout_valid <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (load) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CW'(push) - CW'(load);
      if (load) begin
        dout_valid <= 1'b1;
      end else if (pop) begin
        dout_valid <= 1'b0;
      end
    end
  end

endmodule
